// ==== flist.f ====
+incdir+include
hdl/mailbox_pkg.sv
hdl/mailbox_fifo.sv
hdl/mailbox_ingress.sv
hdl/mailbox_qos_arbiter.sv
hdl/mailbox_enqueue.sv
hdl/mailbox_switch.sv
dv/tb_mailbox_switch.sv

// ==== Bender.yml ====
package:
  name: mailbox_switch

sources:
  - files:
      - hdl/mailbox_pkg.sv
      - hdl/mailbox_fifo.sv
      - hdl/mailbox_ingress.sv
      - hdl/mailbox_qos_arbiter.sv
      - hdl/mailbox_enqueue.sv
      - hdl/mailbox_switch.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/tb_mailbox_switch.sv

// ==== include/mailbox_ref_model.svh ====
`ifndef MAILBOX_REF_MODEL_SVH
`define MAILBOX_REF_MODEL_SVH

// Expected target mask, bit order dl0, dl1, up
function automatic port_mask_t ref_target(input bit from_up, input logic [15:0] addr,
                                          input logic [7:0] own);
  port_mask_t m;
  m = 3'b000;
  if (addr[15:8] == 8'hFF) begin
    m = from_up ? 3'b011 : 3'b111;
  end else if (addr[15:8] != own) begin
    m = from_up ? 3'b000 : 3'b100;
  end else if (addr[7:0] == 8'hFF) begin
    m = 3'b011;
  end else if (addr[7:0] < 8'd2) begin
    m = addr[0] ? 3'b010 : 3'b001;
  end
  return m;
endfunction

// Hop count saturates at 15, parity is even over data, prio and hops
function automatic mailbox_tag_t ref_tag(input mailbox_tag_t t, input logic [31:0] data);
  mailbox_tag_t r;
  logic p;
  r = t;
  if (r.hops < 4'd15) r.hops = r.hops + 4'd1;
  p = r.prio;
  for (int i = 0; i < 32; i++) p = p ^ data[i];
  for (int i = 0; i < 4; i++) p = p ^ r.hops[i];
  r.parity = p;
  return r;
endfunction

// Winning source for one output, -1 when nothing is eligible
function automatic int ref_winner(input port_mask_t req, input port_mask_t prio,
                                  input logic [2:0][3:0] hops, input int rr, input int lat);
  port_mask_t elig;
  int win;
  int idx;
  elig = req;
  // Three latency grants in a row force a best-effort turn
  if (lat == 3 && (req & ~prio) != 3'b000) elig = req & ~prio;
  else if ((req & prio) != 3'b000) elig = req & prio;
  win = -1;
  for (int i = 0; i < 3; i++) begin
    idx = (rr + i) % 3;
    if (elig[idx] && (win < 0 || hops[idx] > hops[win])) win = idx;
  end
  return win;
endfunction

`endif

// ==== dv/tb_mailbox_switch.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_mailbox_switch import mailbox_pkg::*; ();

  localparam logic [7:0]  cluster_id = 8'h01;
  localparam int          fifo_depth = 2;
  localparam int          num_txn    = 31;
  localparam int          max_cycles = 40 * num_txn + 200;
  localparam logic [15:0] up_addr    = 16'h3C05;

  logic clk = 1'b0;
  logic rst_n;
  logic [2:0] awvalid, wvalid, bready, m_ready;
  logic [2:0][addr_w-1:0] awaddr;
  logic [2:0][data_w-1:0] wdata;
  logic [2:0][strb_w-1:0] wstrb;
  mailbox_tag_t [2:0] tag_in;
  wire  [2:0] awready, wready, bvalid, m_awvalid, m_wvalid;
  wire  [2:0][addr_w-1:0] m_awaddr;
  wire  [2:0][data_w-1:0] m_wdata;
  wire  [2:0][strb_w-1:0] m_wstrb;
  wire  [2:0][5:0] m_tag;

  flit_t exp_dl0[$];
  flit_t exp_dl1[$];
  flit_t exp_up[$];
  flit_t head;
  int    rr_m[3];
  int    lat_m[3];
  int    acc_cnt[3];
  int    b_cnt[3];
  int    errors, checks, fails, err_start, cycles, seed_val;
  int    test_num = 1;

  `include "mailbox_ref_model.svh"

  always #50 clk = ~clk;

  mailbox_switch #(.cluster_id(cluster_id), .fifo_depth(fifo_depth)) dut (
    .clk(clk), .rst_n(rst_n),
    .dl0_awvalid(awvalid[0]), .dl0_awready(awready[0]), .dl0_awaddr(awaddr[0]),
    .dl0_wvalid(wvalid[0]), .dl0_wready(wready[0]), .dl0_wdata(wdata[0]),
    .dl0_wstrb(wstrb[0]), .dl0_tag(tag_in[0]), .dl0_bvalid(bvalid[0]), .dl0_bready(bready[0]),
    .dl1_awvalid(awvalid[1]), .dl1_awready(awready[1]), .dl1_awaddr(awaddr[1]),
    .dl1_wvalid(wvalid[1]), .dl1_wready(wready[1]), .dl1_wdata(wdata[1]),
    .dl1_wstrb(wstrb[1]), .dl1_tag(tag_in[1]), .dl1_bvalid(bvalid[1]), .dl1_bready(bready[1]),
    .up_awvalid(awvalid[2]), .up_awready(awready[2]), .up_awaddr(awaddr[2]),
    .up_wvalid(wvalid[2]), .up_wready(wready[2]), .up_wdata(wdata[2]),
    .up_wstrb(wstrb[2]), .up_tag(tag_in[2]), .up_bvalid(bvalid[2]), .up_bready(bready[2]),
    .m_dl0_awvalid(m_awvalid[0]), .m_dl0_awready(m_ready[0]), .m_dl0_awaddr(m_awaddr[0]),
    .m_dl0_wvalid(m_wvalid[0]), .m_dl0_wready(m_ready[0]), .m_dl0_wdata(m_wdata[0]),
    .m_dl0_wstrb(m_wstrb[0]), .m_dl0_tag(m_tag[0]),
    .m_dl1_awvalid(m_awvalid[1]), .m_dl1_awready(m_ready[1]), .m_dl1_awaddr(m_awaddr[1]),
    .m_dl1_wvalid(m_wvalid[1]), .m_dl1_wready(m_ready[1]), .m_dl1_wdata(m_wdata[1]),
    .m_dl1_wstrb(m_wstrb[1]), .m_dl1_tag(m_tag[1]),
    .m_up_awvalid(m_awvalid[2]), .m_up_awready(m_ready[2]), .m_up_awaddr(m_awaddr[2]),
    .m_up_wvalid(m_wvalid[2]), .m_up_wready(m_ready[2]), .m_up_wdata(m_wdata[2]),
    .m_up_wstrb(m_wstrb[2]), .m_up_tag(m_tag[2])
  );

  function automatic string port_name(input int p);
    case (p)
      0: return "dl0";
      1: return "dl1";
      default: return "up";
    endcase
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("Error: %s", msg);
  endtask

  function automatic int expected_count(input int o);
    case (o)
      0: return exp_dl0.size();
      1: return exp_dl1.size();
      default: return exp_up.size();
    endcase
  endfunction

  task automatic push_expected(input int o, input flit_t f);
    case (o)
      0: exp_dl0.push_back(f);
      1: exp_dl1.push_back(f);
      default: exp_up.push_back(f);
    endcase
  endtask

  task automatic pop_expected(input int o, output flit_t f);
    case (o)
      0: f = exp_dl0.pop_front();
      1: f = exp_dl1.pop_front();
      default: f = exp_up.pop_front();
    endcase
  endtask

  // Expected flits per output plus the arbiter state they imply
  task automatic record_accept(input int p);
    port_mask_t tgt;
    flit_t f;
    tgt   = ref_target(p == 2, awaddr[p], cluster_id);
    f.adr  = awaddr[p];
    f.dat  = wdata[p];
    f.strb = wstrb[p];
    f.tag  = ref_tag(tag_in[p], wdata[p]);
    if (tgt == 3'b000) report_error($sformatf("%s accepted an unroutable write", port_name(p)));
    for (int o = 0; o < 3; o++) begin
      if (tgt[o]) begin
        push_expected(o, f);
        rr_m[o] = (rr_m[o] + 1) % 3;
        if (!tag_in[p].prio) lat_m[o] = 0;
        else if (lat_m[o] < 3) lat_m[o] = lat_m[o] + 1;
      end
    end
    acc_cnt[p]++;
  endtask

  // --------------------------------------------------
  // Checker and handshake monitor
  // --------------------------------------------------
  always @(posedge clk) begin
    if (rst_n) begin
      for (int o = 0; o < 3; o++) begin
        if (m_awvalid[o] && m_ready[o]) begin
          if (expected_count(o) == 0) begin
            report_error($sformatf("unexpected write left output %s", port_name(o)));
          end else begin
            pop_expected(o, head);
            check($sformatf("m_%s_awaddr", port_name(o)), m_awaddr[o], head.adr);
            check($sformatf("m_%s_wdata", port_name(o)), m_wdata[o], head.dat);
            check($sformatf("m_%s_wstrb", port_name(o)), m_wstrb[o], head.strb);
            check($sformatf("m_%s_tag", port_name(o)), m_tag[o], head.tag);
            check($sformatf("m_%s_wvalid", port_name(o)), m_wvalid[o], 1'b1);
          end
        end
      end
      for (int p = 0; p < 3; p++) begin
        if (bvalid[p] && bready[p]) b_cnt[p]++;
        if (awvalid[p] && wvalid[p] && awready[p]) begin
          if (!wready[p]) report_error($sformatf("%s awready without wready", port_name(p)));
          if (bvalid[p]) report_error($sformatf("%s accepted with a B pending", port_name(p)));
          record_accept(p);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > max_cycles) begin
      $display("Run stopped: still busy after %0d cycles", max_cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  function automatic mailbox_tag_t make_tag(input logic prio, input logic [3:0] hops);
    mailbox_tag_t t;
    t.prio   = prio;
    t.hops   = hops;
    t.parity = 1'b0;
    return t;
  endfunction

  function automatic mailbox_tag_t rand_tag();
    logic [31:0] r;
    r = $urandom;
    return make_tag(r[0], r[4:1]);
  endfunction

  // --------------------------------------------------
  // Drivers, all inputs change on the falling edge
  // --------------------------------------------------
  task automatic present(input int p, input logic [15:0] addr, input mailbox_tag_t t);
    awaddr[p]  = addr;
    wdata[p]   = $urandom;
    wstrb[p]   = 4'($urandom);
    tag_in[p]  = t;
    awvalid[p] = 1'b1;
    wvalid[p]  = 1'b1;
  endtask

  // Called 1 ns after a falling edge, returns at the same point
  task automatic wait_accept(input int p, input int limit, output bit ok);
    int n;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < limit) begin
      if (awready[p]) begin
        ok = 1'b1;
        @(negedge clk);
        awvalid[p] = 1'b0;
        wvalid[p]  = 1'b0;
        #1;
      end else begin
        @(negedge clk);
        #1;
        n++;
      end
    end
  endtask

  task automatic write_one(input int p, input logic [15:0] addr, input mailbox_tag_t t,
                           input int limit, output bit ok);
    @(negedge clk);
    present(p, addr, t);
    #1;
    wait_accept(p, limit, ok);
  endtask

  task automatic send(input int p, input logic [15:0] addr, input mailbox_tag_t t);
    bit ok;
    write_one(p, addr, t, 20, ok);
    if (!ok) report_error($sformatf("%s write to %h never accepted", port_name(p), addr));
  endtask

  task automatic withdraw(input int p);
    @(negedge clk);
    awvalid[p] = 1'b0;
    wvalid[p]  = 1'b0;
    #1;
  endtask

  // Both leaves present a write to up in the same cycle
  task automatic race_to_up(input mailbox_tag_t t0, input mailbox_tag_t t1);
    int win;
    bit ok;
    @(negedge clk);
    present(0, up_addr, t0);
    present(1, up_addr, t1);
    win = ref_winner(3'b011, {1'b0, t1.prio, t0.prio}, {4'd0, t1.hops, t0.hops},
                     rr_m[2], lat_m[2]);
    #1;
    check("dl0_awready", awready[0], win == 0);
    check("dl1_awready", awready[1], win == 1);
    wait_accept(win, 5, ok);
    wait_accept(1 - win, 10, ok);
    if (!ok) report_error("losing write to up was never served");
  endtask

  task automatic finish_test(input string name);
    int n;
    n = 0;
    while (expected_count(0) + expected_count(1) + expected_count(2) > 0 && n < 50) begin
      @(negedge clk);
      n++;
    end
    if (expected_count(0) + expected_count(1) + expected_count(2) > 0) begin
      report_error("expected writes never left the switch");
      exp_dl0.delete();
      exp_dl1.delete();
      exp_up.delete();
    end
    repeat (2) @(negedge clk);
    for (int p = 0; p < 3; p++) check({port_name(p), " B count"}, b_cnt[p], acc_cnt[p]);
    if (errors != err_start) fails++;
    $display("test %0d %s: %s", test_num, name, (errors == err_start) ? "pass" : "fail");
    test_num++;
    err_start = errors;
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    bit ok;
    seed_val = $urandom(32'h9b47_2bce);
    rst_n   = 1'b0;
    awvalid = '0;
    wvalid  = '0;
    bready  = '1;
    m_ready = '1;
    awaddr  = '0;
    wdata   = '0;
    wstrb   = '0;
    tag_in  = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int p = 0; p < 3; p++) begin
      for (int d = 0; d < 3; d++) begin
        if (!(p == 2 && d == 2)) send(p, (d == 2) ? up_addr : {cluster_id, 8'(d)}, rand_tag());
      end
    end
    send(0, {cluster_id, 8'h01}, make_tag(1'b0, 4'd15));
    send(2, {cluster_id, 8'h00}, make_tag(1'b1, 4'd14));
    finish_test("unicast routing and tag update");

    for (int p = 0; p < 3; p++) begin
      send(p, {cluster_id, broadcast_id}, rand_tag());
      send(p, {broadcast_id, 8'($urandom)}, rand_tag());
    end
    finish_test("broadcasts");

    write_one(2, up_addr, rand_tag(), 20, ok);
    if (ok) report_error("uplink write to a foreign cluster was accepted");
    withdraw(2);
    write_one(0, {cluster_id, 8'h02}, rand_tag(), 20, ok);
    if (ok) report_error("write to local id 2 was accepted");
    withdraw(0);
    finish_test("unroutable writes stall");

    bready[1] = 1'b0;
    send(1, {cluster_id, 8'h00}, rand_tag());
    @(negedge clk);
    present(1, up_addr, rand_tag());
    for (int n = 0; n < 4; n++) begin
      #1;
      check("dl1_bvalid", bvalid[1], 1'b1);
      check("dl1_awready", awready[1], 1'b0);
      @(negedge clk);
    end
    bready[1] = 1'b1;
    #1;
    wait_accept(1, 5, ok);
    if (!ok) report_error("dl1 write after its B response was never accepted");
    finish_test("B responses");

    @(negedge clk);
    m_ready[0] = 1'b0;
    for (int n = 0; n < fifo_depth; n++) send(1 + n % 2, {cluster_id, 8'h00}, rand_tag());
    write_one(1, {cluster_id, 8'h00}, rand_tag(), 10, ok);
    if (ok) report_error("write accepted while the dl0 queue was full");
    @(negedge clk);
    m_ready[0] = 1'b1;
    #1;
    wait_accept(1, 10, ok);
    if (!ok) report_error("stalled dl0 write not accepted after release");
    finish_test("back-pressure");

    // Latency beats an older best-effort flit, then best effort gets its forced turn
    send(1, up_addr, make_tag(1'b0, 4'd3));
    race_to_up(make_tag(1'b1, 4'd2), make_tag(1'b0, 4'd9));
    for (int n = 0; n < 3; n++) send(n % 2, up_addr, make_tag(1'b1, 4'(n)));
    race_to_up(make_tag(1'b1, 4'd12), make_tag(1'b0, 4'd1));
    finish_test("QoS arbitration");

    $display("%0d tests, %0d failed, %0d checks, %0d errors", test_num - 1, fails, checks,
             errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/mailbox_switch.sv ====
`default_nettype none
`timescale 1ns/100ps

module mailbox_switch import mailbox_pkg::*; #(
  parameter logic [7:0] cluster_id = 8'h01,
  parameter int         fifo_depth = 2
) (
  input  logic clk,
  input  logic rst_n,
  // Leaf and uplink masters
  input  logic dl0_awvalid, output logic dl0_awready, input logic [addr_w-1:0] dl0_awaddr,
  input  logic dl0_wvalid,  output logic dl0_wready,  input logic [data_w-1:0] dl0_wdata,
  input  logic [strb_w-1:0] dl0_wstrb, input mailbox_tag_t dl0_tag,
  output logic dl0_bvalid,  input  logic dl0_bready,
  input  logic dl1_awvalid, output logic dl1_awready, input logic [addr_w-1:0] dl1_awaddr,
  input  logic dl1_wvalid,  output logic dl1_wready,  input logic [data_w-1:0] dl1_wdata,
  input  logic [strb_w-1:0] dl1_wstrb, input mailbox_tag_t dl1_tag,
  output logic dl1_bvalid,  input  logic dl1_bready,
  input  logic up_awvalid,  output logic up_awready,  input logic [addr_w-1:0] up_awaddr,
  input  logic up_wvalid,   output logic up_wready,   input logic [data_w-1:0] up_wdata,
  input  logic [strb_w-1:0] up_wstrb, input mailbox_tag_t up_tag,
  output logic up_bvalid,   input  logic up_bready,
  // Outbound slaves, write only
  output logic m_dl0_awvalid, input logic m_dl0_awready, output logic [addr_w-1:0] m_dl0_awaddr,
  output logic m_dl0_wvalid,  input logic m_dl0_wready,  output logic [data_w-1:0] m_dl0_wdata,
  output logic [strb_w-1:0] m_dl0_wstrb, output mailbox_tag_t m_dl0_tag,
  output logic m_dl1_awvalid, input logic m_dl1_awready, output logic [addr_w-1:0] m_dl1_awaddr,
  output logic m_dl1_wvalid,  input logic m_dl1_wready,  output logic [data_w-1:0] m_dl1_wdata,
  output logic [strb_w-1:0] m_dl1_wstrb, output mailbox_tag_t m_dl1_tag,
  output logic m_up_awvalid,  input logic m_up_awready,  output logic [addr_w-1:0] m_up_awaddr,
  output logic m_up_wvalid,   input logic m_up_wready,   output logic [data_w-1:0] m_up_wdata,
  output logic [strb_w-1:0] m_up_wstrb, output mailbox_tag_t m_up_tag
);

  logic       [num_ports-1:0]      req, accept, sel_valid, enq;
  port_mask_t [num_ports-1:0]      tgt, arb_req;
  flit_t      [num_ports-1:0]      flit, fifo_w_data, fifo_head;
  port_mask_t                      prio;
  logic       [num_ports-1:0][3:0] hops;
  port_idx_t  [num_ports-1:0]      sel;
  logic       [num_ports-1:0]      fifo_full, fifo_w_en, fifo_empty, out_ready;

  // --------------------------------------------------
  // Ingress ports
  // --------------------------------------------------
  mailbox_ingress #(.cluster_id(cluster_id), .is_uplink(1'b0)) u_ingress_dl0 (
    .clk(clk), .rst_n(rst_n), .awvalid(dl0_awvalid), .awready(dl0_awready),
    .awaddr(dl0_awaddr), .wvalid(dl0_wvalid), .wready(dl0_wready), .wdata(dl0_wdata),
    .wstrb(dl0_wstrb), .tag(dl0_tag), .bvalid(dl0_bvalid), .bready(dl0_bready),
    .req(req[0]), .tgt(tgt[0]), .flit(flit[0]), .accept(accept[0])
  );

  mailbox_ingress #(.cluster_id(cluster_id), .is_uplink(1'b0)) u_ingress_dl1 (
    .clk(clk), .rst_n(rst_n), .awvalid(dl1_awvalid), .awready(dl1_awready),
    .awaddr(dl1_awaddr), .wvalid(dl1_wvalid), .wready(dl1_wready), .wdata(dl1_wdata),
    .wstrb(dl1_wstrb), .tag(dl1_tag), .bvalid(dl1_bvalid), .bready(dl1_bready),
    .req(req[1]), .tgt(tgt[1]), .flit(flit[1]), .accept(accept[1])
  );

  mailbox_ingress #(.cluster_id(cluster_id), .is_uplink(1'b1)) u_ingress_up (
    .clk(clk), .rst_n(rst_n), .awvalid(up_awvalid), .awready(up_awready),
    .awaddr(up_awaddr), .wvalid(up_wvalid), .wready(up_wready), .wdata(up_wdata),
    .wstrb(up_wstrb), .tag(up_tag), .bvalid(up_bvalid), .bready(up_bready),
    .req(req[2]), .tgt(tgt[2]), .flit(flit[2]), .accept(accept[2])
  );

  mailbox_enqueue u_enqueue (
    .req(req), .tgt(tgt), .flit(flit), .accept(accept),
    .arb_req(arb_req), .prio(prio), .hops(hops), .sel(sel), .sel_valid(sel_valid),
    .enq(enq), .fifo_full(fifo_full), .fifo_w_en(fifo_w_en), .fifo_w_data(fifo_w_data)
  );

  // --------------------------------------------------
  // Per-output arbiter and queue
  // --------------------------------------------------
  assign out_ready = {m_up_awready & m_up_wready,
                      m_dl1_awready & m_dl1_wready,
                      m_dl0_awready & m_dl0_wready};

  for (genvar o = 0; o < num_ports; o++) begin : g_out
    mailbox_qos_arbiter u_arbiter (
      .clk(clk), .rst_n(rst_n), .arb_req(arb_req[o]), .prio(prio), .hops(hops),
      .enq(enq[o]), .sel(sel[o]), .sel_valid(sel_valid[o])
    );

    mailbox_fifo #(.T(flit_t), .depth(fifo_depth)) u_fifo (
      .clk(clk), .rst_n(rst_n), .w_en(fifo_w_en[o]), .w_data(fifo_w_data[o]),
      .full(fifo_full[o]), .r_en(!fifo_empty[o] && out_ready[o]),
      .r_data(fifo_head[o]), .empty(fifo_empty[o])
    );
  end

  // Outbound writes are fire and forget
  assign m_dl0_awvalid = !fifo_empty[0];
  assign m_dl0_wvalid  = !fifo_empty[0];
  assign m_dl0_awaddr  = fifo_head[0].adr;
  assign m_dl0_wdata   = fifo_head[0].dat;
  assign m_dl0_wstrb   = fifo_head[0].strb;
  assign m_dl0_tag     = fifo_head[0].tag;

  assign m_dl1_awvalid = !fifo_empty[1];
  assign m_dl1_wvalid  = !fifo_empty[1];
  assign m_dl1_awaddr  = fifo_head[1].adr;
  assign m_dl1_wdata   = fifo_head[1].dat;
  assign m_dl1_wstrb   = fifo_head[1].strb;
  assign m_dl1_tag     = fifo_head[1].tag;

  assign m_up_awvalid  = !fifo_empty[2];
  assign m_up_wvalid   = !fifo_empty[2];
  assign m_up_awaddr   = fifo_head[2].adr;
  assign m_up_wdata    = fifo_head[2].dat;
  assign m_up_wstrb    = fifo_head[2].strb;
  assign m_up_tag      = fifo_head[2].tag;

endmodule

`default_nettype wire

// ==== hdl/mailbox_enqueue.sv ====
`default_nettype none
`timescale 1ns/100ps

module mailbox_enqueue import mailbox_pkg::*; (
  // Per source
  input  logic       [num_ports-1:0]      req,
  input  port_mask_t [num_ports-1:0]      tgt,
  input  flit_t      [num_ports-1:0]      flit,
  output logic       [num_ports-1:0]      accept,

  // Per output, toward the arbiters
  output port_mask_t [num_ports-1:0]      arb_req,
  output port_mask_t                      prio,
  output logic       [num_ports-1:0][3:0] hops,
  input  port_idx_t  [num_ports-1:0]      sel,
  input  logic       [num_ports-1:0]      sel_valid,
  output logic       [num_ports-1:0]      enq,

  // Per output, toward the FIFOs
  input  logic       [num_ports-1:0]      fifo_full,
  output logic       [num_ports-1:0]      fifo_w_en,
  output flit_t      [num_ports-1:0]      fifo_w_data
);

  // --------------------------------------------------
  // Requests seen by each output arbiter
  // --------------------------------------------------
  always_comb begin
    for (int s = 0; s < num_ports; s++) begin
      prio[s] = flit[s].tag.prio;
      hops[s] = flit[s].tag.hops;
    end
    for (int o = 0; o < num_ports; o++) begin
      for (int s = 0; s < num_ports; s++) begin
        arb_req[o][s] = req[s] && tgt[s][o] && !fifo_full[o];
      end
    end
  end

  // Broadcast needs every targeted output to pick the same source
  always_comb begin
    for (int s = 0; s < num_ports; s++) begin
      accept[s] = req[s] && (tgt[s] != '0);
      for (int o = 0; o < num_ports; o++) begin
        if (tgt[s][o] && !(sel_valid[o] && (sel[o] == port_idx_t'(s)))) begin
          accept[s] = 1'b0;
        end
      end
    end
  end

  // --------------------------------------------------
  // FIFO write mux
  // --------------------------------------------------
  always_comb begin
    fifo_w_en   = '0;
    fifo_w_data = '0;
    for (int s = 0; s < num_ports; s++) begin
      for (int o = 0; o < num_ports; o++) begin
        if (accept[s] && tgt[s][o]) begin
          fifo_w_en[o]   = 1'b1;
          fifo_w_data[o] = flit[s];
        end
      end
    end
  end

  assign enq = fifo_w_en;

endmodule

`default_nettype wire

// ==== hdl/mailbox_qos_arbiter.sv ====
`default_nettype none
`timescale 1ns/100ps

module mailbox_qos_arbiter import mailbox_pkg::*; (
  input  logic                          clk,
  input  logic                          rst_n,
  input  port_mask_t                    arb_req,
  input  port_mask_t                    prio,
  input  logic [num_ports-1:0][3:0]     hops,
  input  logic                          enq,
  output port_idx_t                     sel,
  output logic                          sel_valid
);

  port_idx_t  rr_ptr;
  logic [1:0] lat_cnt;

  logic       any_lat;
  logic       any_be;
  logic       force_be;
  port_mask_t eligible;

  port_idx_t  scan_idx;
  logic [3:0] best_hops;

  // --------------------------------------------------
  // Class filter
  // --------------------------------------------------
  assign any_lat  = |(arb_req & prio);
  assign any_be   = |(arb_req & ~prio);

  // Best effort gets a turn after a run of latency grants
  assign force_be = (lat_cnt == be_min_service) && any_be;

  always_comb begin
    if (force_be) begin
      eligible = arb_req & ~prio;
    end else if (any_lat) begin
      eligible = arb_req & prio;
    end else begin
      eligible = arb_req;
    end
  end

  // --------------------------------------------------
  // Oldest flit wins, scan starts at the round-robin pointer
  // --------------------------------------------------
  always_comb begin
    sel       = '0;
    sel_valid = 1'b0;
    best_hops = '0;
    scan_idx  = '0;
    for (int i = 0; i < num_ports; i++) begin
      if (int'(rr_ptr) + i >= num_ports) begin
        scan_idx = port_idx_t'(int'(rr_ptr) + i - num_ports);
      end else begin
        scan_idx = port_idx_t'(int'(rr_ptr) + i);
      end
      // Strict compare so the earlier source keeps a tie
      if (eligible[scan_idx] && (!sel_valid || (hops[scan_idx] > best_hops))) begin
        sel       = scan_idx;
        sel_valid = 1'b1;
        best_hops = hops[scan_idx];
      end
    end
  end

  // --------------------------------------------------
  // State update on enqueue
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rr_ptr  <= '0;
      lat_cnt <= '0;
    end else if (enq) begin
      if (rr_ptr == port_idx_t'(num_ports - 1)) begin
        rr_ptr <= '0;
      end else begin
        rr_ptr <= rr_ptr + 2'd1;
      end

      if (!prio[sel]) begin
        lat_cnt <= '0;
      end else if (lat_cnt != be_min_service) begin
        lat_cnt <= lat_cnt + 2'd1;
      end
    end
  end

  a_sel_requests: assert property (@(posedge clk) disable iff (!rst_n)
    sel_valid |-> arb_req[sel])
    else $error("selected source %0d has no request", sel);

endmodule

`default_nettype wire

// ==== hdl/mailbox_ingress.sv ====
`default_nettype none
`timescale 1ns/100ps

module mailbox_ingress import mailbox_pkg::*; #(
  parameter logic [7:0] cluster_id = 8'h01,
  parameter bit         is_uplink  = 1'b0
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              awvalid,
  output logic              awready,
  input  logic [addr_w-1:0] awaddr,
  input  logic              wvalid,
  output logic              wready,
  input  logic [data_w-1:0] wdata,
  input  logic [strb_w-1:0] wstrb,
  input  mailbox_tag_t      tag,
  output logic              bvalid,
  input  logic              bready,
  output logic              req,
  output port_mask_t        tgt,
  output flit_t             flit,
  input  logic              accept
);

  // Target masks, bit order dl0, dl1, up
  localparam port_mask_t mask_dl0    = 3'b001;
  localparam port_mask_t mask_dl1    = 3'b010;
  localparam port_mask_t mask_leaves = 3'b011;
  localparam port_mask_t mask_up     = 3'b100;

  logic [7:0] cluster;
  logic [7:0] local_id;
  logic       resp_pending;

  assign cluster  = awaddr[15:8];
  assign local_id = awaddr[7:0];

  // --------------------------------------------------
  // Destination decode
  // --------------------------------------------------
  always_comb begin
    tgt = '0;
    if (cluster == broadcast_id) begin
      // Global broadcast never goes back toward the center
      tgt = is_uplink ? mask_leaves : (mask_leaves | mask_up);
    end else if (cluster == cluster_id) begin
      if (local_id == broadcast_id) tgt = mask_leaves;
      else if (local_id == 8'd0) tgt = mask_dl0;
      else if (local_id == 8'd1) tgt = mask_dl1;
    end else if (!is_uplink) begin
      tgt = mask_up;
    end
  end

  // Empty mask keeps the write stalled here
  assign req = awvalid && wvalid && !resp_pending && (tgt != '0);

  always_comb begin
    flit.adr  = awaddr;
    flit.dat  = wdata;
    flit.strb = wstrb;
    flit.tag  = update_tag(tag, wdata);
  end

  assign awready = accept;
  assign wready  = accept;

  // --------------------------------------------------
  // Write response
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_pending <= 1'b0;
    end else if (resp_pending && bready) begin
      resp_pending <= 1'b0;
    end else if (accept) begin
      resp_pending <= 1'b1;
    end
  end

  assign bvalid = resp_pending;

  a_accept_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    accept |-> req)
    else $error("accept without a pending request");

endmodule

`default_nettype wire

// ==== hdl/mailbox_fifo.sv ====
`default_nettype none
`timescale 1ns/100ps

module mailbox_fifo #(
  parameter type T     = logic,
  parameter int  depth = 2
) (
  input  logic clk,
  input  logic rst_n,
  input  logic w_en,
  input  T     w_data,
  output logic full,
  input  logic r_en,
  output T     r_data,
  output logic empty
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  T                 mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;

  assign full   = (count == cnt_w'(depth));
  assign empty  = (count == '0);
  assign r_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (w_en) mem[wr_ptr] <= w_data;
  end

  // Pointers wrap at depth, count tracks occupancy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (w_en) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (r_en) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({w_en, r_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
    w_en |-> !full)
    else $error("write into full FIFO");

  a_no_read_empty: assert property (@(posedge clk) disable iff (!rst_n)
    r_en |-> !empty)
    else $error("read from empty FIFO");

endmodule

`default_nettype wire

// ==== hdl/mailbox_pkg.sv ====
`default_nettype none

package mailbox_pkg;

  localparam int addr_w    = 16;
  localparam int data_w    = 32;
  localparam int strb_w    = 4;
  localparam int num_ports = 3;

  // Port order: 0 = dl0, 1 = dl1, 2 = up
  typedef logic [1:0]           port_idx_t;
  typedef logic [num_ports-1:0] port_mask_t;

  // Cluster and local id bytes both use FF for broadcast
  localparam logic [7:0] broadcast_id   = 8'hFF;
  localparam logic [3:0] hops_max       = 4'd15;
  localparam logic [1:0] be_min_service = 2'd3;

  typedef struct packed {
    logic       prio;
    logic [3:0] hops;
    logic       parity;
  } mailbox_tag_t;

  typedef struct packed {
    logic [addr_w-1:0] adr;
    logic [data_w-1:0] dat;
    logic [strb_w-1:0] strb;
    mailbox_tag_t      tag;
  } flit_t;

  // Even parity over payload data, prio and hops
  function automatic logic compute_parity(input logic [data_w-1:0] data,
                                          input mailbox_tag_t tag);
    return (^data) ^ tag.prio ^ (^tag.hops);
  endfunction

  function automatic mailbox_tag_t update_tag(input mailbox_tag_t tag_in,
                                              input logic [data_w-1:0] data);
    mailbox_tag_t tag_out;
    tag_out = tag_in;
    if (tag_out.hops != hops_max) tag_out.hops = tag_out.hops + 4'd1;
    tag_out.parity = compute_parity(data, tag_out);
    return tag_out;
  endfunction

endpackage

`default_nettype wire
